/* logic/fpu_consts.svh */
`ifndef FPU_CONSTS_SVH
`define FPU_CONSTS_SVH

// binary32 field widths
`define FP_EXP_W 8      // biased exponent
`define FP_MAN_W 23     // stored fraction, hidden bit not included
`define FP_SIG_W 24     // fraction plus hidden bit

// working mantissa layout, msb first:
//   carry | hidden bit + fraction (24) | guard | round
// the sticky bit is held in its own register next to it
`define FP_EXT_W 27

// an alignment shift past this leaves nothing but sticky
`define FP_ALIGN_MAX 26

// largest biased exponent of a normal number, 255 is inf/nan
`define FP_EXP_MAX 254

`endif

/* logic/fpu_pkg.sv */
`include "fpu_consts.svh"

package fpu_pkg;

    // raw ieee-754 single precision word
    typedef struct packed {
        logic                 sign;
        logic [`FP_EXP_W-1:0] exp;
        logic [`FP_MAN_W-1:0] frac;
    } fp32_t;

    // operand after unpacking, hidden bit made explicit
    // all zero when the input was zero or denormal
    typedef struct packed {
        logic                 sign;
        logic [`FP_EXP_W-1:0] exp;
        logic [`FP_SIG_W-1:0] sig;
    } fp_unpacked_t;

    typedef enum logic {
        op_add = 1'b0,
        op_sub = 1'b1
    } fpu_op_e;

    // sequencer states, one pass per operation
    typedef enum logic [2:0] {
        st_idle  = 3'd0,
        st_load  = 3'd1,   // counter takes the exponent difference
        st_align = 3'd2,   // small mantissa walks right
        st_add   = 3'd3,
        st_norm  = 3'd4,   // one right shift or a run of left shifts
        st_round = 3'd5,
        st_done  = 3'd6
    } fpu_state_e;

endpackage

/* logic/fp_operand_order.sv */
`include "fpu_consts.svh"

module fp_operand_order import fpu_pkg::*; (
    input  fp32_t        a_in,
    input  fp32_t        b_in,
    input  fpu_op_e      op,
    output fp_unpacked_t big_op,
    output fp_unpacked_t small_op,
    output logic         eff_sub,
    output logic         result_sign
);

    fp_unpacked_t ua;
    fp_unpacked_t ub;
    logic         b_sign_eff;     // sign of b as seen by the adder
    logic         swap;

    // subtraction is addition of b with its sign flipped
    assign b_sign_eff = b_in.sign ^ (op == op_sub);

    always_comb begin
        ua = '0;                   // exp 0 means zero or denormal, both flushed
        if (a_in.exp != '0) begin
            ua.sign = a_in.sign;
            ua.exp  = a_in.exp;
            ua.sig  = {1'b1, a_in.frac};
        end
    end

    always_comb begin
        ub = '0;
        if (b_in.exp != '0) begin
            ub.sign = b_sign_eff;
            ub.exp  = b_in.exp;
            ub.sig  = {1'b1, b_in.frac};
        end
    end

    // magnitude compare, exponent first then significand
    assign swap = {ub.exp, ub.sig} > {ua.exp, ua.sig};

    assign big_op   = swap ? ub : ua;
    assign small_op = swap ? ua : ub;

    // differing signs make the adder subtract
    assign eff_sub = a_in.sign ^ b_sign_eff;

    // larger magnitude wins the sign
    // equal magnitudes cancel to zero and round_pack forces +0 there
    assign result_sign = big_op.sign;

endmodule

/* logic/fpu_ctrl.sv */
module fpu_ctrl import fpu_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic sum_carry,
    input  logic sig_msb,
    input  logic sum_zero,
    input  logic cnt_zero,
    output logic load_en,
    output logic align_step,
    output logic add_en,
    output logic norm_step,
    output logic norm_right,
    output logic cnt_load,
    output logic cnt_sel_norm,
    output logic cnt_step,
    output logic round_en,
    output logic busy,
    output logic done
);

    fpu_state_e state;
    fpu_state_e state_nxt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt    = state;
        load_en      = 1'b0;
        align_step   = 1'b0;
        add_en       = 1'b0;
        norm_step    = 1'b0;
        norm_right   = 1'b0;
        cnt_load     = 1'b0;
        cnt_sel_norm = 1'b0;
        cnt_step     = 1'b0;
        round_en     = 1'b0;
        case (state)
            st_idle: begin
                load_en = start;           // operands captured on the start cycle itself
                if (start) begin
                    state_nxt = st_load;
                end
            end
            st_load: begin
                cnt_load  = 1'b1;          // exp_diff comes from the captured exponents
                state_nxt = st_align;
            end
            st_align: begin
                if (cnt_zero) begin
                    state_nxt = st_add;
                end else begin
                    align_step = 1'b1;
                    cnt_step   = 1'b1;
                end
            end
            st_add: begin
                add_en       = 1'b1;
                cnt_load     = 1'b1;       // reload as the left shift bound
                cnt_sel_norm = 1'b1;
                state_nxt    = st_norm;
            end
            st_norm: begin
                if (sum_zero) begin
                    state_nxt = st_round;  // nothing to normalize
                end else if (sum_carry) begin
                    norm_step  = 1'b1;     // single right shift absorbs the carry
                    norm_right = 1'b1;
                    state_nxt  = st_round;
                end else if (sig_msb || cnt_zero) begin
                    state_nxt = st_round;
                end else begin
                    norm_step = 1'b1;      // left, one bit per cycle
                    cnt_step  = 1'b1;
                end
            end
            st_round: begin
                round_en  = 1'b1;
                state_nxt = st_done;
            end
            st_done: begin
                state_nxt = st_idle;       // a start here is dropped
            end
            default: begin
                state_nxt = st_idle;
            end
        endcase
    end

    // both drop at the same edge
    assign busy = (state != st_idle);
    assign done = (state == st_done);

endmodule

/* logic/shift_counter.sv */
`include "fpu_consts.svh"

module shift_counter (
    input  logic       clk,
    input  logic       rst,
    input  logic       cnt_load,
    input  logic       cnt_sel_norm,
    input  logic       cnt_step,
    input  logic [7:0] exp_diff,
    output logic       cnt_zero
);

    logic [4:0] cnt;        // holds 0..26
    logic [4:0] load_val;

    // align amount is saturated, shifts beyond it only feed sticky
    // normalize needs 25 at most, so the same limit bounds it too
    always_comb begin
        if (cnt_sel_norm || (exp_diff > `FP_ALIGN_MAX)) begin
            load_val = 5'(`FP_ALIGN_MAX);
        end else begin
            load_val = exp_diff[4:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt <= '0;
        end else if (cnt_load) begin
            cnt <= load_val;
        end else if (cnt_step && !cnt_zero) begin
            cnt <= cnt - 5'd1;     // never wraps below zero
        end
    end

    assign cnt_zero = (cnt == '0);

endmodule

/* logic/mant_datapath.sv */
`include "fpu_consts.svh"

module mant_datapath import fpu_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               load_en,
    input  logic               align_step,
    input  logic               add_en,
    input  logic               norm_step,
    input  logic               norm_right,
    input  fp_unpacked_t       big_op,
    input  fp_unpacked_t       small_op,
    input  logic               eff_sub,
    input  logic               result_sign,
    output logic [7:0]         exp_diff,
    output logic               sum_carry,
    output logic               sig_msb,
    output logic               sum_zero,
    output logic [23:0]        norm_sig,
    output logic               guard,
    output logic               round,
    output logic               sticky,
    output logic               res_sign,
    output logic signed [9:0]  res_exp
);

    logic [`FP_EXT_W-1:0] acc_m;     // larger mantissa and later the sum
    logic [`FP_EXT_W-1:0] sml_m;     // smaller mantissa shifted during align
    logic [`FP_EXT_W-1:0] sticky_w;  // sticky widened for the borrow
    logic [`FP_EXP_W-1:0] sml_exp;
    logic                 sticky_r;  // or of every bit shifted out the bottom
    logic signed [9:0]    exp_w;     // working exponent that can dip below 1
    logic                 sub_r;
    logic                 sign_r;

    assign sticky_w = {{(`FP_EXT_W-1){1'b0}}, sticky_r};

    // mantissa payload
    always_ff @(posedge clk) begin
        if (load_en) begin
            acc_m   <= {1'b0, big_op.sig, 2'b00};    // carry | sig | g r
            sml_m   <= {1'b0, small_op.sig, 2'b00};
            sml_exp <= small_op.exp;
        end else if (align_step) begin
            sml_m <= sml_m >> 1;
        end else if (add_en) begin
            if (sub_r) begin
                // a set sticky means the true small value is a bit larger,
                // so borrow one and leave sticky standing for the remainder
                acc_m <= acc_m - sml_m - sticky_w;
            end else begin
                acc_m <= acc_m + sml_m;
            end
        end else if (norm_step) begin
            if (norm_right) begin
                acc_m <= acc_m >> 1;
            end else begin
                acc_m <= acc_m << 1;   // zero enters round while sticky still covers below
            end
        end
    end

    // sticky, exponent and the operation flags
    always_ff @(posedge clk) begin
        if (rst) begin
            sticky_r <= 1'b0;
            exp_w    <= '0;
            sub_r    <= 1'b0;
            sign_r   <= 1'b0;
        end else if (load_en) begin
            sticky_r <= 1'b0;
            exp_w    <= {2'b00, big_op.exp};
            sub_r    <= eff_sub;
            sign_r   <= result_sign;
        end else if (align_step) begin
            sticky_r <= sticky_r | sml_m[0];
        end else if (norm_step) begin
            if (norm_right) begin
                sticky_r <= sticky_r | acc_m[0];
                exp_w    <= exp_w + 10'sd1;
            end else begin
                exp_w <= exp_w - 10'sd1;
            end
        end
    end

    // ordering keeps the big exponent at or above the small one
    // a zero small operand needs no alignment at all
    assign exp_diff = sml_m[`FP_EXT_W-2] ? (exp_w[7:0] - sml_exp) : 8'd0;

    assign sum_carry = acc_m[`FP_EXT_W-1];
    assign sig_msb   = acc_m[`FP_EXT_W-2];     // hidden bit position
    assign sum_zero  = (acc_m == '0);

    assign norm_sig = acc_m[`FP_EXT_W-2:2];
    assign guard    = acc_m[1];
    assign round    = acc_m[0];
    assign sticky   = sticky_r;
    assign res_sign = sign_r;
    assign res_exp  = exp_w;

endmodule

/* logic/round_pack.sv */
`include "fpu_consts.svh"

module round_pack import fpu_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              round_en,
    input  logic [23:0]       norm_sig,
    input  logic              guard,
    input  logic              round,
    input  logic              sticky,
    input  logic              res_sign,
    input  logic              sum_zero,
    input  logic signed [9:0] res_exp,
    output fp32_t             result
);

    logic                 inc;
    logic [`FP_SIG_W:0]   sig_rnd;   // one extra bit catches the carry out
    logic signed [9:0]    exp_rnd;
    fp32_t                pack_v;

    // nearest even, ties go to the even lsb
    assign inc = guard & (round | sticky | norm_sig[0]);

    assign sig_rnd = {1'b0, norm_sig} + {{`FP_SIG_W{1'b0}}, inc};

    // 1.111..1 + 1 gives 10.000..0, fraction bits already zero
    assign exp_rnd = res_exp + $signed({9'd0, sig_rnd[`FP_SIG_W]});

    always_comb begin
        pack_v = '0;                              // +0 for cancel and underflow
        if (sum_zero || (exp_rnd < 10'sd1)) begin
            pack_v = '0;
        end else if (exp_rnd > `FP_EXP_MAX) begin // exp_rnd known positive here
            pack_v.sign = res_sign;
            pack_v.exp  = '1;                     // infinity, fraction stays 0
        end else begin
            pack_v.sign = res_sign;
            pack_v.exp  = exp_rnd[`FP_EXP_W-1:0];
            pack_v.frac = sig_rnd[`FP_MAN_W-1:0];
        end
    end

    // result only moves in the round cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            result <= '0;
        end else if (round_en) begin
            result <= pack_v;
        end
    end

endmodule

/* logic/fp_addsub_top.sv */
module fp_addsub_top import fpu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    start,
    input  fpu_op_e op,
    input  fp32_t   a_in,
    input  fp32_t   b_in,
    output fp32_t   result,
    output logic    busy,
    output logic    done
);

    fp_unpacked_t      big_op;
    fp_unpacked_t      small_op;
    logic              eff_sub;
    logic              result_sign;
    logic              load_en;
    logic              align_step;
    logic              add_en;
    logic              norm_step;
    logic              norm_right;
    logic              cnt_load;
    logic              cnt_sel_norm;
    logic              cnt_step;
    logic              round_en;
    logic              cnt_zero;
    logic [7:0]        exp_diff;
    logic              sum_carry;
    logic              sig_msb;
    logic              sum_zero;
    logic [23:0]       norm_sig;
    logic              guard;
    logic              round;
    logic              sticky;
    logic              res_sign;
    logic signed [9:0] res_exp;

    fp_operand_order u_order (
        .a_in        (a_in),
        .b_in        (b_in),
        .op          (op),
        .big_op      (big_op),
        .small_op    (small_op),
        .eff_sub     (eff_sub),
        .result_sign (result_sign)
    );

    fpu_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .start        (start),
        .sum_carry    (sum_carry),
        .sig_msb      (sig_msb),
        .sum_zero     (sum_zero),
        .cnt_zero     (cnt_zero),
        .load_en      (load_en),
        .align_step   (align_step),
        .add_en       (add_en),
        .norm_step    (norm_step),
        .norm_right   (norm_right),
        .cnt_load     (cnt_load),
        .cnt_sel_norm (cnt_sel_norm),
        .cnt_step     (cnt_step),
        .round_en     (round_en),
        .busy         (busy),
        .done         (done)
    );

    // one counter bounds both align and normalize
    shift_counter u_cnt (
        .clk          (clk),
        .rst          (rst),
        .cnt_load     (cnt_load),
        .cnt_sel_norm (cnt_sel_norm),
        .cnt_step     (cnt_step),
        .exp_diff     (exp_diff),
        .cnt_zero     (cnt_zero)
    );

    mant_datapath u_dp (
        .clk         (clk),
        .rst         (rst),
        .load_en     (load_en),
        .align_step  (align_step),
        .add_en      (add_en),
        .norm_step   (norm_step),
        .norm_right  (norm_right),
        .big_op      (big_op),
        .small_op    (small_op),
        .eff_sub     (eff_sub),
        .result_sign (result_sign),
        .exp_diff    (exp_diff),
        .sum_carry   (sum_carry),
        .sig_msb     (sig_msb),
        .sum_zero    (sum_zero),
        .norm_sig    (norm_sig),
        .guard       (guard),
        .round       (round),
        .sticky      (sticky),
        .res_sign    (res_sign),
        .res_exp     (res_exp)
    );

    round_pack u_rnd (
        .clk      (clk),
        .rst      (rst),
        .round_en (round_en),
        .norm_sig (norm_sig),
        .guard    (guard),
        .round    (round),
        .sticky   (sticky),
        .res_sign (res_sign),
        .sum_zero (sum_zero),
        .res_exp  (res_exp),
        .result   (result)
    );

endmodule

/* sim/fp_addsub_tb.sv */
`include "fpu_consts.svh"

module fp_addsub_tb import fpu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_ADD   = 300;
    localparam int N_SUB   = 300;
    localparam int N_FAR   = 150;
    localparam int N_ZERO  = 100;
    localparam int N_EDGE  = 150;
    localparam int N_PROTO = 20;
    localparam int N_OPS   = N_ADD + N_SUB + N_FAR + N_ZERO + N_EDGE + N_PROTO;
    localparam int MAX_CYCLES = N_OPS * 60 + 100;   // worst op is under 60 cycles
    localparam int OP_LIMIT   = 70;                 // per operation wait for done

    logic    clk;
    logic    rst;
    logic    start;
    fpu_op_e op;
    fp32_t   a_in;
    fp32_t   b_in;
    fp32_t   result;
    logic    busy;
    logic    done;

    logic [31:0] rng_state;
    fp32_t       prev_result;   // last value result must hold
    int          err_count;
    int          check_count;
    int          op_count;
    int          cycle_count;

    fp_addsub_top dut (
        .clk    (clk),
        .rst    (rst),
        .start  (start),
        .op     (op),
        .a_in   (a_in),
        .b_in   (b_in),
        .result (result),
        .busy   (busy),
        .done   (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;   // 100 ns period
    end

    // whole-run limit
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic int rand_range(input int lo, input int hi);
        return lo + int'(next_rand() % 32'(hi - lo + 1));
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = next_rand();
        return r[16];
    endfunction

    function automatic logic [22:0] rand_frac();
        return 23'(next_rand());
    endfunction

    function automatic fp32_t make_fp(input logic s, input int e, input logic [22:0] f);
        fp32_t v;
        v.sign = s;
        v.exp  = 8'(e);
        v.frac = f;
        return v;
    endfunction

    // exact sum in a 64 bit integer with 32 fraction bits under the lsb,
    // then one rounding to nearest even at unbounded exponent
    function automatic fp32_t ref_addsub(input fp32_t a, input fp32_t b, input fpu_op_e o);
        logic        s_a;
        logic        s_b;
        logic        s_hi;
        logic        sub;
        logic [23:0] sa;
        logic [23:0] sb;
        logic [23:0] sig_hi;
        logic [23:0] sig_lo;
        int          ea;
        int          eb;
        int          exp_hi;
        int          d;
        int          p;
        int          rsh;
        int          e;
        logic [63:0] va;
        logic [63:0] vb;
        logic [63:0] r;
        logic [63:0] rem;
        logic [63:0] half;
        logic [24:0] sig;
        fp32_t       res;
        s_a = a.sign;
        s_b = b.sign ^ (o == op_sub);                       // sub is add of -b
        sa  = (a.exp == 8'd0) ? 24'd0 : {1'b1, a.frac};     // exp 0 counts as zero
        sb  = (b.exp == 8'd0) ? 24'd0 : {1'b1, b.frac};
        ea  = (a.exp == 8'd0) ? 0 : int'(a.exp);
        eb  = (b.exp == 8'd0) ? 0 : int'(b.exp);
        sub = s_a ^ s_b;
        if (eb > ea || (eb == ea && sb > sa)) begin
            sig_hi = sb;
            sig_lo = sa;
            exp_hi = eb;
            s_hi   = s_b;
            d      = eb - ea;
        end else begin
            sig_hi = sa;
            sig_lo = sb;
            exp_hi = ea;
            s_hi   = s_a;
            d      = ea - eb;
        end
        va = {8'd0, sig_hi, 32'd0};               // hidden bit lands on bit 55
        if (sig_lo == 24'd0) begin
            vb = '0;
        end else if (d > 32) begin
            vb = 64'd1;                           // far below round so only presence matters
        end else begin
            vb = {8'd0, sig_lo, 32'd0} >> d;      // exact since nothing drops off
        end
        r   = sub ? va - vb : va + vb;
        res = '0;
        if (r == 64'd0) begin
            return res;                           // cancel or both zero gives +0
        end
        p = 63;
        while (!r[p]) begin
            p--;
        end
        e   = exp_hi + p - 55;
        rsh = p - 23;                             // bits below the 24 bit significand
        if (rsh > 0) begin
            sig  = 25'(r >> rsh);
            rem  = r & ((64'd1 << rsh) - 64'd1);
            half = 64'd1 << (rsh - 1);
            if (rem > half || (rem == half && sig[0])) begin
                sig = sig + 25'd1;
            end
        end else begin
            sig = 25'(r << (-rsh));
        end
        if (sig[24]) begin                        // rounding spilled into a new bit
            sig = sig >> 1;
            e   = e + 1;
        end
        if (e < 1) begin
            res = '0;
        end else if (e > `FP_EXP_MAX) begin
            res.sign = s_hi;
            res.exp  = 8'hff;
        end else begin
            res.sign = s_hi;
            res.exp  = 8'(e);
            res.frac = sig[22:0];
        end
        return res;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] expv);
        check_count++;
        if (got !== expv) begin
            err_count++;
            $display("error at %0d ns: %s is %h, expected %h", $time, name, got, expv);
        end
    endtask

    // one operation with the protocol watched every cycle until done
    task automatic run_op(input fp32_t a, input fp32_t b, input fpu_op_e o, input logic poke);
        fp32_t expv;
        int    waited;
        expv = ref_addsub(a, b, o);
        @(posedge clk);
        a_in  <= a;
        b_in  <= b;
        op    <= o;
        start <= 1'b1;
        @(posedge clk);
        start  <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (!done && waited < OP_LIMIT) begin
            check_val("busy", 32'(busy), 32'd1);
            check_val("result before round", result, prev_result);
            @(posedge clk);
            if (poke && waited == 2) begin
                start <= 1'b1;                    // fsm is busy so this start must be dropped
                a_in  <= next_rand();
                b_in  <= next_rand();
                op    <= (op == op_add) ? op_sub : op_add;
            end else if (poke && waited == 3) begin
                start <= 1'b0;
            end
            @(negedge clk);
            waited++;
        end
        if (!done) begin
            err_count++;
            $display("done did not arrive within %0d cycles of start at %0d ns",
                     OP_LIMIT, $time);
        end else begin
            check_val("busy with done", 32'(busy), 32'd1);
            check_val($sformatf("result of %h %s %h", a, (o == op_sub) ? "-" : "+", b),
                      result, expv);
            prev_result = result;
            @(negedge clk);
            check_val("done one cycle", 32'(done), 32'd0);
            check_val("busy after done", 32'(busy), 32'd0);
            check_val("result held", result, prev_result);
        end
        op_count++;
    endtask

    task automatic report_test(input string name, input int n, input int err_before);
        $display("test %s: %0d ops, %0d errors", name, n, err_count - err_before);
    endtask

    task automatic random_adds(input int n);
        int    err_before;
        int    ea;
        logic  s;
        fp32_t a;
        fp32_t b;
        err_before = err_count;
        for (int i = 0; i < n; i++) begin
            ea = rand_range(31, 220);
            s  = rand_bit();                      // same signs give a true addition
            a  = make_fp(s, ea, rand_frac());
            b  = make_fp(s, ea + rand_range(-30, 30), rand_frac());
            run_op(a, b, op_add, 1'b0);
        end
        report_test("random additions", n, err_before);
    endtask

    task automatic random_subs(input int n);
        int          err_before;
        int          ea;
        logic        s;
        logic [22:0] fa;
        fp32_t       a;
        fp32_t       b;
        err_before = err_count;
        for (int i = 0; i < n; i++) begin
            ea = rand_range(30, 220);
            s  = rand_bit();
            fa = rand_frac();
            a  = make_fp(s, ea, fa);
            case (rand_range(0, 3))
                0: b = a;                                           // exact cancel
                1: b = make_fp(s, ea, rand_frac());
                2: b = make_fp(s, ea, fa ^ 23'(next_rand() & 32'hff)); // long left shift
                default: b = make_fp(s, ea + rand_range(-3, 3), rand_frac());
            endcase
            run_op(a, b, op_sub, 1'b0);
        end
        report_test("random subtractions", n, err_before);
    endtask

    task automatic far_exponents(input int n);
        int      err_before;
        int      ea;
        fpu_op_e o;
        fp32_t   a;
        fp32_t   b;
        err_before = err_count;
        for (int i = 0; i < n; i++) begin
            ea = rand_range(60, 254);
            a  = make_fp(rand_bit(), ea, rand_frac());
            b  = make_fp(rand_bit(), ea - rand_range(27, 58), rand_frac());  // sticky only
            o  = rand_bit() ? op_sub : op_add;
            if (rand_bit()) begin
                run_op(b, a, o, 1'b0);            // small one first
            end else begin
                run_op(a, b, o, 1'b0);
            end
        end
        report_test("far exponents", n, err_before);
    endtask

    task automatic zero_operands(input int n);
        int      err_before;
        int      mode;
        fpu_op_e o;
        fp32_t   z1;
        fp32_t   z2;
        fp32_t   nv;
        fp32_t   direct;
        err_before = err_count;
        for (int i = 0; i < n; i++) begin
            mode = rand_range(0, 2);
            o    = rand_bit() ? op_sub : op_add;
            z1   = make_fp(rand_bit(), 0, rand_bit() ? rand_frac() : 23'd0);  // zero or denormal
            z2   = make_fp(rand_bit(), 0, rand_bit() ? rand_frac() : 23'd0);
            nv   = make_fp(rand_bit(), rand_range(1, 254), rand_frac());
            direct = nv;
            case (mode)
                0: begin
                    run_op(z1, nv, o, 1'b0);
                    direct.sign = nv.sign ^ (o == op_sub);
                end
                1: run_op(nv, z1, o, 1'b0);
                default: begin
                    run_op(z1, z2, o, 1'b0);
                    direct = '0;
                end
            endcase
            check_val("result against zero rule", result, direct);
        end
        report_test("zero and denormal", n, err_before);
    endtask

    task automatic range_limits(input int n);
        int          err_before;
        int          ea;
        int          eb;
        int          inf_cnt;
        int          zero_cnt;
        logic        s;
        logic [22:0] fa;
        err_before = err_count;
        inf_cnt    = 0;
        zero_cnt   = 0;
        for (int i = 0; i < n; i++) begin
            s  = rand_bit();
            fa = rand_frac();
            if (rand_bit()) begin
                ea = rand_range(250, 254);        // top of the range where the sum may overflow
                eb = ea - rand_range(0, 2);
                run_op(make_fp(s, ea, fa), make_fp(s, eb, rand_frac()), op_add, 1'b0);
            end else begin
                ea = rand_range(1, 4);            // near cancel at the bottom
                eb = ea - rand_range(0, 1);
                if (eb < 1) begin
                    eb = 1;
                end
                run_op(make_fp(s, ea, fa), make_fp(s, eb, fa ^ 23'(next_rand() & 32'hfff)),
                       op_sub, 1'b0);
            end
            if (result.exp == 8'hff) begin
                inf_cnt++;
            end
            if (result == '0) begin
                zero_cnt++;
            end
        end
        report_test($sformatf("range limits (%0d inf, %0d zero)", inf_cnt, zero_cnt),
                    n, err_before);
    endtask

    task automatic protocol_checks(input int n);
        int    err_before;
        int    ea;
        fp32_t a;
        fp32_t b;
        err_before = err_count;
        for (int i = 0; i < n; i++) begin
            ea = rand_range(100, 150);
            a  = make_fp(rand_bit(), ea, rand_frac());
            b  = make_fp(rand_bit(), ea + rand_range(-5, 5), rand_frac());
            run_op(a, b, rand_bit() ? op_sub : op_add, 1'b1);
            repeat (3) begin                      // stray start must not have restarted it
                @(negedge clk);
                check_val("busy while idle", 32'(busy), 32'd0);
                check_val("result while idle", result, prev_result);
            end
        end
        report_test("protocol", n, err_before);
    endtask

    initial begin
        rst         = 1'b1;
        start       = 1'b0;
        op          = op_add;
        a_in        = '0;
        b_in        = '0;
        rng_state   = 32'd5;
        prev_result = '0;
        err_count   = 0;
        check_count = 0;
        op_count    = 0;
        cycle_count = 0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_val("busy after reset", 32'(busy), 32'd0);
        check_val("done after reset", 32'(done), 32'd0);
        check_val("result after reset", result, 32'd0);

        random_adds(N_ADD);
        random_subs(N_SUB);
        far_exponents(N_FAR);
        zero_operands(N_ZERO);
        range_limits(N_EDGE);
        protocol_checks(N_PROTO);

        $display("tests 6, operations %0d, checks %0d, errors %0d",
                 op_count, check_count, err_count);
        if (err_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* build.f */
+incdir+logic
logic/fpu_pkg.sv
logic/fp_operand_order.sv
logic/fpu_ctrl.sv
logic/shift_counter.sv
logic/mant_datapath.sv
logic/round_pack.sv
logic/fp_addsub_top.sv
sim/fp_addsub_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = fp_addsub_tb
FILELIST  = build.f
OBJ_DIR   = obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Simulation passed"

clean:
	rm -rf $(OBJ_DIR)
